// ==== verilog/aprPkg.sv ====
// Shared APR types. Data path bits use PDP-10 numbering (bit 0 is MSB); CROM fields count from LSB
package aprPkg;

   ////////////////////
   // Control ROM fields
   ////////////////////

   // Special-select field position, counted from the LSB of the CROM word
   localparam int specFieldLsb = 45;
   localparam int specSelWidth = 5;

   // Enable-20 bit, just above the select field
   localparam int specEn20Bit  = 50;

   // Microcode special-select values
   // Unlisted selects fall through to no action
   typedef enum logic [specSelWidth-1:0] {
      specNone      = 5'h00,
      specRsvd1     = 5'h01,
      specRsvd2     = 5'h02,
      specAprFlags  = 5'h0b,
      specAprEnable = 5'h0d,
      specRsvd3     = 5'h1f
   } specSel_t;

   ////////////////////
   // Interrupt levels
   ////////////////////

   // PI levels 1..7, level 1 is highest priority
   localparam int numLevels  = 7;
   localparam int levelWidth = 3;

   ////////////////////
   // APR command
   ////////////////////

   typedef enum logic [1:0] {
      opNone       = 2'd0,
      opLoadEnable = 2'd1,
      opLoadFlags  = 2'd2
   } aprOp_t;

   // Data path bits 22..35, MSB first
   typedef struct packed {
      logic                  trapEn;   // dp[22]
      logic                  pageEn;   // dp[23]
      logic [24:31]          bits8;    // Flags or enables
      logic                  swInt;    // dp[32]
      logic [levelWidth-1:0] pri;      // dp[33:35]
   } aprData_t;

   // Stage 1 to stage 2 payload
   typedef struct packed {
      aprOp_t   op;
      aprData_t data;
   } aprCmd_t;

   // APR flag word, bits 22..35
   typedef struct packed {
      logic       trapEn;
      logic       pageEn;
      logic       flag24;
      logic       flag25;
      logic       flag26;
      logic       flag27;
      logic       flag28;
      logic       flag29;
      logic       flag30;
      logic       flag31;
      logic       intReq;
      logic [2:0] ones;
   } aprFlags_t;

endpackage

// ==== verilog/specDecode.sv ====
// Stage 1 decode; the CROM word must be wider than specEn20Bit, and a command lasts one cycle
`timescale 1ns/100ps

module specDecode
#(
   parameter int cromWidth = 108
)
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   clken,
   input  logic [cromWidth-1:0]   crom,
   input  logic [0:35]            dp,
   output aprPkg::aprCmd_t        cmd
);

   logic              specEn20;
   aprPkg::specSel_t  specSel;
   aprPkg::aprOp_t    nextOp;

   ////////////////////
   // Field extraction
   ////////////////////

   assign specEn20 = crom[aprPkg::specEn20Bit];
   assign specSel  = aprPkg::specSel_t'(crom[aprPkg::specFieldLsb +: aprPkg::specSelWidth]);

   // Select to opcode, both loads need enable-20
   always_comb
   begin
      nextOp = aprPkg::opNone;
      if (specEn20)
      begin
         case (specSel)
            aprPkg::specAprEnable : nextOp = aprPkg::opLoadEnable;
            aprPkg::specAprFlags  : nextOp = aprPkg::opLoadFlags;
            default               : nextOp = aprPkg::opNone;
         endcase
      end
   end

   ////////////////////
   // Pipeline register
   ////////////////////

   // Clock enable applied here only
   // Idle cycles load opNone so a command is a single-cycle strobe
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         cmd <= '0;
      else
      begin
         cmd.op   <= clken ? nextOp : aprPkg::opNone;
         cmd.data <= dp[22:35];
      end
   end

endmodule

// ==== verilog/aprDevice.sv ====
// Stage 2 APR device; flags 26, 28-30 are software bits only, hardware sets win over a flags load
`timescale 1ns/100ps

module aprDevice
(
   input  logic                           clk,
   input  logic                           rst,
   input  aprPkg::aprCmd_t                cmd,
   input  logic                           nxmIntr,
   input  logic                           cslIntr,
   output aprPkg::aprFlags_t              flags,
   output logic [1:aprPkg::numLevels]     intr
);

   logic [24:31]       flagReg;
   aprPkg::aprData_t   enaReg;
   logic               intReq;

   ////////////////////
   // Flag register
   ////////////////////

   // 24   software interrupt
   // 25   console interrupt request
   // 26   power fail
   // 27   non-existent memory
   // 28   uncorrectable memory error
   // 29   correctable memory error
   // 30   interval timer, microcode managed
   // 31   console to KS10 interrupt
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         flagReg <= '0;
      else
      begin
         if (cmd.op == aprPkg::opLoadFlags)
            flagReg <= cmd.data.bits8;
         // Sticky sets, later assignment overrides the load
         if (nxmIntr)
            flagReg[27] <= 1'b1;
         if (cslIntr)
            flagReg[31] <= 1'b1;
      end
   end

   ////////////////////
   // Enable register
   ////////////////////

   // Trap, paging, per-flag enables, software int and priority
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         enaReg <= '0;
      else if (cmd.op == aprPkg::opLoadEnable)
         enaReg <= cmd.data;
   end

   ////////////////////
   // Interrupt request
   ////////////////////

   // Any enabled flag, or the software interrupt
   assign intReq = (|(flagReg & enaReg.bits8)) | enaReg.swInt;

   // Priority to one-hot level, pri zero means no request
   always_comb
   begin
      intr = '0;
      for (int lvl = 1; lvl <= aprPkg::numLevels; lvl++)
      begin
         if (intReq && (int'(enaReg.pri) == lvl))
            intr[lvl] = 1'b1;
      end
   end

   ////////////////////
   // Flag word
   ////////////////////

   // Bits 33..35 always read as ones
   assign flags = '{
      trapEn : enaReg.trapEn,
      pageEn : enaReg.pageEn,
      flag24 : flagReg[24],
      flag25 : flagReg[25],
      flag26 : flagReg[26],
      flag27 : flagReg[27],
      flag28 : flagReg[28],
      flag29 : flagReg[29],
      flag30 : flagReg[30],
      flag31 : flagReg[31],
      intReq : intReq,
      ones   : 3'b111
   };

endmodule

// ==== verilog/piArbiter.sv ====
// Stage 3 PI arbiter; level 1 wins, no acknowledge cycle or in-progress tracking
`timescale 1ns/100ps

module piArbiter
(
   input  logic                                clk,
   input  logic                                rst,
   input  logic [1:aprPkg::numLevels]          aprIntr,
   input  logic [1:aprPkg::numLevels]          extIntr,
   output logic                                piReq,
   output logic [aprPkg::levelWidth-1:0]       piLevel
);

   logic [1:aprPkg::numLevels]       merged;
   logic                             nextReq;
   logic [aprPkg::levelWidth-1:0]    nextLevel;

   ////////////////////
   // Request merge
   ////////////////////

   // APR shares the levels with the other devices
   assign merged  = aprIntr | extIntr;
   assign nextReq = |merged;

   ////////////////////
   // Priority encode
   ////////////////////

   // Scan from lowest priority up
   // Lower level numbers overwrite, so level 1 ends on top
   always_comb
   begin
      nextLevel = '0;
      for (int lvl = aprPkg::numLevels; lvl >= 1; lvl--)
      begin
         if (merged[lvl])
            nextLevel = aprPkg::levelWidth'(lvl);
      end
   end

   ////////////////////
   // Output register
   ////////////////////

   // Held stable for microcode dispatch
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         piReq   <= 1'b0;
         piLevel <= '0;
      end
      else
      begin
         piReq   <= nextReq;
         piLevel <= nextLevel;
      end
   end

endmodule

// ==== verilog/aprSystem.sv ====
// APR top level; decode, device and arbiter in series, no back-pressure, extIntr is level style
`timescale 1ns/100ps

module aprSystem
#(
   parameter int cromWidth = 108
)
(
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              clken,
   input  logic [cromWidth-1:0]              crom,
   input  logic [0:35]                       dp,
   input  logic                              nxmIntr,
   input  logic                              cslIntr,
   input  logic [1:aprPkg::numLevels]        extIntr,
   output aprPkg::aprFlags_t                 aprFlags,
   output logic [1:aprPkg::numLevels]        aprIntr,
   output logic                              piReq,
   output logic [aprPkg::levelWidth-1:0]     piLevel
);

   // Stage 1 to stage 2
   aprPkg::aprCmd_t aprCmd;

   specDecode #(.cromWidth(cromWidth)) u_specDecode (
      .clk   (clk),
      .rst   (rst),
      .clken (clken),
      .crom  (crom),
      .dp    (dp),
      .cmd   (aprCmd)
   );

   aprDevice u_aprDevice (
      .clk     (clk),
      .rst     (rst),
      .cmd     (aprCmd),
      .nxmIntr (nxmIntr),
      .cslIntr (cslIntr),
      .flags   (aprFlags),
      .intr    (aprIntr)
   );

   piArbiter u_piArbiter (
      .clk     (clk),
      .rst     (rst),
      .aprIntr (aprIntr),
      .extIntr (extIntr),
      .piReq   (piReq),
      .piLevel (piLevel)
   );

endmodule

// ==== verif/aprSystem_sva.sv ====
// Shadow model of the APR pipeline built from the top-level ports; expects the package CROM layout
`timescale 1ns/100ps

module aprSystemSva
#(
   parameter int cromWidth = 108
)
(
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           clken,
   input  logic [cromWidth-1:0]           crom,
   input  logic [0:35]                    dp,
   input  logic                           nxmIntr,
   input  logic                           cslIntr,
   input  logic [1:aprPkg::numLevels]     extIntr,
   input  aprPkg::aprFlags_t              aprFlags,
   input  logic [1:aprPkg::numLevels]     aprIntr,
   input  logic                           piReq,
   input  logic [aprPkg::levelWidth-1:0]  piLevel
);

   // Level 1 sits in the MSB of a level vector
   localparam logic [1:aprPkg::numLevels] levelOne = {1'b1, {(aprPkg::numLevels-1){1'b0}}};

   int                             failCount = 0;
   logic                           loadFlags;
   logic                           loadEna;
   aprPkg::aprData_t               loadData;
   logic [24:31]                   flagModel;
   aprPkg::aprData_t               enaModel;
   logic [1:aprPkg::numLevels]     prevMerge;
   logic [24:31]                   flagsSeen;
   logic                           reqModel;
   logic [1:aprPkg::numLevels]     intrModel;

   // Count one failure and report it
   task automatic countFailure(string sigName, logic [31:0] expVal, logic [31:0] gotVal);
      failCount++;
      $error("ERR %s expected %h got %h", sigName, expVal, gotVal);
   endtask

   // First set level, scanning from level 1
   function automatic logic [aprPkg::levelWidth-1:0] lowestLevel(logic [1:aprPkg::numLevels] req);
      logic [aprPkg::levelWidth-1:0] lvl;
      lvl = '0;
      for (int i = 1; i <= aprPkg::numLevels; i++)
      begin
         if (req[i] && lvl == '0)
            lvl = aprPkg::levelWidth'(i);
      end
      return lvl;
   endfunction

   ////////////////////
   // Reference model
   ////////////////////

   // Decode edge, then the APR state one edge later
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         loadFlags <= 1'b0;
         loadEna   <= 1'b0;
         loadData  <= '0;
         flagModel <= '0;
         enaModel  <= '0;
         prevMerge <= '0;
      end
      else
      begin
         loadFlags <= clken && crom[aprPkg::specEn20Bit] &&
                      (crom[aprPkg::specFieldLsb +: 5] == aprPkg::specAprFlags);
         loadEna   <= clken && crom[aprPkg::specEn20Bit] &&
                      (crom[aprPkg::specFieldLsb +: 5] == aprPkg::specAprEnable);
         loadData  <= dp[22:35];
         if (loadEna)
            enaModel <= loadData;
         // NXM lands on 27, console on 31, both over a load
         flagModel <= (loadFlags ? loadData.bits8 : flagModel) | {3'b0, nxmIntr, 3'b0, cslIntr};
         prevMerge <= aprIntr | extIntr;
      end
   end

   assign flagsSeen = {aprFlags.flag24, aprFlags.flag25, aprFlags.flag26, aprFlags.flag27,
                       aprFlags.flag28, aprFlags.flag29, aprFlags.flag30, aprFlags.flag31};
   assign reqModel  = (|(flagModel & enaModel.bits8)) | enaModel.swInt;
   assign intrModel = (reqModel && enaModel.pri != '0) ? (levelOne >> (enaModel.pri - 3'd1)) : '0;

   ////////////////////
   // Checks
   ////////////////////

   // Reset values, constant ones in 33..35
   assert property (@(posedge clk) rst |->
      (aprFlags == 14'h0007 && aprIntr == '0 && !piReq && piLevel == '0))
   else countFailure("aprFlags/aprIntr/piReq/piLevel at reset",
                     32'({14'h0007, {(aprPkg::numLevels + 1 + aprPkg::levelWidth){1'b0}}}),
                     32'({aprFlags, aprIntr, piReq, piLevel}));

   assert property (@(posedge clk) disable iff (rst) flagsSeen == flagModel)
   else countFailure("aprFlags.flag24..31", 32'(flagModel), 32'(flagsSeen));

   assert property (@(posedge clk) disable iff (rst)
      {aprFlags.trapEn, aprFlags.pageEn} == {enaModel.trapEn, enaModel.pageEn})
   else countFailure("aprFlags.trapEn/pageEn", 32'({enaModel.trapEn, enaModel.pageEn}),
                     32'({aprFlags.trapEn, aprFlags.pageEn}));

   // Masking against the read-back flags
   assert property (@(posedge clk) disable iff (rst)
      aprFlags.intReq == ((|(flagsSeen & enaModel.bits8)) | enaModel.swInt))
   else countFailure("aprFlags.intReq", 32'((|(flagsSeen & enaModel.bits8)) | enaModel.swInt),
                     32'(aprFlags.intReq));

   assert property (@(posedge clk) disable iff (rst) aprIntr == intrModel)
   else countFailure("aprIntr", 32'(intrModel), 32'(aprIntr));

   assert property (@(posedge clk) disable iff (rst)
      piReq == (|prevMerge) && piLevel == lowestLevel(prevMerge))
   else countFailure("piReq/piLevel", 32'({|prevMerge, lowestLevel(prevMerge)}),
                     32'({piReq, piLevel}));

endmodule

bind aprSystem aprSystemSva #(.cromWidth(cromWidth)) u_sva (.*);

// ==== verif/aprSystemTb.sv ====
// Directed then random stimulus for the APR pipeline; the bound assertions judge, default CROM only
`timescale 1ns/100ps

module aprSystemTb;

   localparam int cromBits    = 108;
   localparam int numRandom   = 400;
   localparam int numDirected = 80;
   localparam int period      = 40;

   logic                             clk = 1'b0;
   logic                             rst;
   logic                             clken;
   logic [cromBits-1:0]              crom;
   logic [0:35]                      dp;
   logic                             nxmIntr;
   logic                             cslIntr;
   logic [1:aprPkg::numLevels]       extIntr;
   aprPkg::aprFlags_t                aprFlags;
   logic [1:aprPkg::numLevels]       aprIntr;
   logic                             piReq;
   logic [aprPkg::levelWidth-1:0]    piLevel;
   integer                           seed;
   logic [31:0]                      r;

   aprSystem u_dut (.*);

   always #(period/2) clk = ~clk;

   // Inputs move 2 ns after the rising edge
   task automatic nextCycle();
      @(posedge clk);
      #2;
   endtask

   // One enabled command with enable-20 set, then clken drops
   task automatic sendCmd(input logic [4:0] sel, input logic [0:13] data);
      nextCycle();
      clken = 1'b1;
      crom = '0;
      crom[aprPkg::specEn20Bit] = 1'b1;
      crom[aprPkg::specFieldLsb +: 5] = sel;
      dp[22:35] = data;
      nextCycle();
      clken = 1'b0;
   endtask

   initial
   begin
      seed    = 10;
      rst     = 1'b1;
      clken   = 1'b0;
      crom    = '0;
      dp      = '0;
      nxmIntr = 1'b0;
      cslIntr = 1'b0;
      extIntr = '0;
      repeat (3) @(posedge clk);
      #2;
      rst = 1'b0;

      ////////////////////
      // Directed preamble
      ////////////////////

      // data is trap, page, bits 24..31, swInt, pri
      sendCmd(aprPkg::specAprFlags, {2'b00, 8'ha5, 4'h0});
      sendCmd(aprPkg::specAprEnable, {2'b11, 8'hff, 4'h3});
      // Every priority with swInt forcing the request
      for (int p = 0; p < 8; p++)
      begin
         sendCmd(aprPkg::specAprEnable, {2'b01, 8'h00, 1'b1, 3'(p)});
         repeat (2) nextCycle();
      end
      // Zero flags load meets both hardware pulses on one edge
      sendCmd(aprPkg::specAprFlags, 14'h0);
      nxmIntr = 1'b1;
      cslIntr = 1'b1;
      nextCycle();
      nxmIntr = 1'b0;
      cslIntr = 1'b0;
      // Walk the external levels
      for (int lvl = 1; lvl <= aprPkg::numLevels; lvl++)
      begin
         extIntr = '0;
         extIntr[lvl] = 1'b1;
         nextCycle();
      end

      ////////////////////
      // Random phase
      ////////////////////

      for (int i = 0; i < numRandom; i++)
      begin
         nextCycle();
         repeat (4)
         begin
            r = $random(seed);
            crom = {crom[cromBits-33:0], r};
         end
         r = $random(seed);
         crom[aprPkg::specEn20Bit] = |r[1:0];
         // Half raw selects, reserved ones included
         if (r[2])
            crom[aprPkg::specFieldLsb +: 5] = r[8:4];
         else if (r[3])
            crom[aprPkg::specFieldLsb +: 5] = aprPkg::specAprFlags;
         else
            crom[aprPkg::specFieldLsb +: 5] = aprPkg::specAprEnable;
         clken   = r[9] | r[10];
         nxmIntr = &r[13:11];
         cslIntr = &r[16:14];
         extIntr = r[23:17] & r[30:24];
         r = $random(seed);
         dp = {r[3:0], $random(seed)};
      end

      clken   = 1'b0;
      nxmIntr = 1'b0;
      cslIntr = 1'b0;
      extIntr = '0;
      repeat (4) nextCycle();
      $display("Summary: %0d assertion failures, %0d random cycles",
               u_dut.u_sva.failCount, numRandom);
      if (u_dut.u_sva.failCount == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

   // Watchdog, sized from reset, directed and random cycles plus margin
   initial
   begin
      #((3 + numDirected + numRandom + 50) * period);
      $display("Timeout: stimulus did not complete in the expected time");
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

// ==== aprSystem.f ====
verilog/aprPkg.sv
verilog/specDecode.sv
verilog/aprDevice.sv
verilog/piArbiter.sv
verilog/aprSystem.sv
verif/aprSystem_sva.sv
verif/aprSystemTb.sv

// ==== Makefile ====
# Verilator build and run of the APR pipeline testbench

TOP = aprSystemTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f aprSystem.f
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
